/* all.f */
common/cu_pkg.sv
design/alu.sv
control_unit/microstore_rom.sv
control_unit/microsequencer.sv
datapath/datapath.sv
design/cpu_top.sv
dv/cpu_tb.sv

/* Makefile */
# Verilator build and run for the microprogrammed CPU testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench, run it and search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^TESTS PASSED$$" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/cpu_tb.sv */
// Testbench for the microprogrammed CPU
// Memory model, program builders, reference interpreter and store checks

`timescale 1ns/1ps

module cpu_tb;
	import cu_pkg::*;

	localparam logic [7:0] RESET_PC     = 8'h20;
	localparam int         HALT_TIMEOUT = 2000;

	logic        clk;
	logic        rst_n;
	logic [7:0]  mem_addr;
	logic        mem_rd;
	logic        mem_wr;
	logic [7:0]  mem_wdata;
	logic [7:0]  mem_rdata;
	logic        halted;
	logic [7:0]  mem [256];
	logic [7:0]  ref_mem [256];
	logic [15:0] exp_mem [256];  // Predicted stores as {address, data}
	logic [15:0] exp_head;
	int          exp_n;
	int          exp_rd;
	logic        exp_halt;
	logic [7:0]  wp;
	int          errors;
	int          stores;

	cpu_top #(.RESET_PC(RESET_PC)) uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_addr  (mem_addr),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.halted    (halted)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	assign mem_rdata = mem[mem_addr];
	assign exp_head  = exp_mem[exp_rd[7:0]];

	always @(posedge clk) begin
		if (mem_wr)
			mem[mem_addr] = mem_wdata;
	end

	always @(posedge clk) begin
		if (!rst_n)
			exp_rd <= 0;
		else if (mem_wr && exp_rd < exp_n)
			exp_rd <= exp_rd + 1;  // Pop the store that was just checked
	end

	store_expected: assert property (@(posedge clk) disable iff (!rst_n)
			mem_wr |-> exp_rd < exp_n)
		else begin
			errors++;
			$display("Store to 0x%02h that the reference model did not predict",
				$sampled(mem_addr));
		end

	store_match: assert property (@(posedge clk) disable iff (!rst_n)
			mem_wr && exp_rd < exp_n |-> {mem_addr, mem_wdata} == exp_head)
		else begin
			errors++;
			$display("Fail mem_addr/mem_wdata: got 0x%02h/0x%02h, expected 0x%02h/0x%02h",
				$sampled(mem_addr), $sampled(mem_wdata), $sampled(exp_head[15:8]),
				$sampled(exp_head[7:0]));
		end

	halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
			halted |-> !mem_rd && !mem_wr)
		else begin
			errors++;
			$display("Memory strobe active while the core is halted");
		end

	halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
		else begin
			errors++;
			$display("halted dropped without a reset");
		end

	reset_fetch: assert property (@(posedge clk) $rose(rst_n) |-> mem_rd && mem_addr == RESET_PC)
		else begin
			errors++;
			$display("Fail mem_rd/mem_addr after reset: got %0h/0x%02h, expected 1/0x%02h",
				$sampled(mem_rd), $sampled(mem_addr), RESET_PC);
		end

	task automatic emit_short(input opcode_e op, input int rd, input int rs);
		mem[wp] = {op, 2'(rd), 2'(rs)};
		wp = wp + 8'd1;
	endtask

	task automatic emit_long(input opcode_e op, input int rd, input int rs, input logic [7:0] b2);
		emit_short(op, rd, rs);
		mem[wp] = b2;
		wp = wp + 8'd1;
	endtask

	// Runs the program in memory from RESET_PC and records every store it makes
	task automatic interpret();
		logic [7:0] r [4];
		logic [7:0] pc;
		logic [7:0] ir;
		logic [7:0] b2;
		logic [7:0] a;
		logic [7:0] b;
		logic [8:0] res;
		logic       z;
		logic       c;
		opcode_e    op;
		int         steps;
		ref_mem  = mem;
		pc       = RESET_PC;
		z        = 1'b0;
		c        = 1'b0;
		exp_n    = 0;
		exp_halt = 1'b0;
		foreach (r[i])
			r[i] = 8'h00;
		for (steps = 0; steps < 500 && !exp_halt; steps++) begin
			ir = ref_mem[pc];
			op = opcode_e'(ir[7:4]);
			pc = pc + 8'd1;
			b2 = ref_mem[pc];
			if (op inside {OP_LDI, OP_LD, OP_ST, OP_JMP, OP_JZ, OP_JC})
				pc = pc + 8'd1;
			a   = r[ir[3:2]];
			b   = r[ir[1:0]];
			res = {c, a};
			case (op)
				OP_LDI: r[ir[3:2]] = b2;
				OP_LD:  r[ir[3:2]] = ref_mem[b2];
				OP_ST: begin
					ref_mem[b2]    = a;
					exp_mem[exp_n] = {b2, a};
					exp_n++;
				end
				OP_ADD: res = {1'b0, a} + {1'b0, b};
				OP_SUB: res = {a >= b, a - b};  // Carry means no borrow
				OP_AND: res = {1'b0, a & b};
				OP_OR:  res = {1'b0, a | b};
				OP_XOR: res = {1'b0, a ^ b};
				OP_SHL: res = {a, 1'b0};
				OP_SHR: res = {a[0], 1'b0, a[7:1]};
				OP_MOV: r[ir[3:2]] = b;
				OP_JMP: pc = b2;
				OP_JZ:  pc = z ? b2 : pc;
				OP_JC:  pc = c ? b2 : pc;
				OP_HLT: exp_halt = 1'b1;
				default: ;
			endcase
			if (op >= OP_ADD && op <= OP_SHR) begin
				r[ir[3:2]] = res[7:0];
				c          = res[8];
				z          = (res[7:0] == 8'h00);
			end
		end
	endtask

	task automatic restart();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (10) @(posedge clk);
		interpret();
		rst_n <= 1'b1;
	endtask

	task automatic run_program(input string name);
		int n;
		restart();
		n = 0;
		while (!halted && n < HALT_TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (!halted) begin
			errors++;
			$display("%s: halted not seen within %0d cycles", name, HALT_TIMEOUT);
		end else if (!exp_halt) begin
			errors++;
			$display("%s: core halted but the reference model never reached HLT", name);
		end
		repeat (50) @(posedge clk);
		if (exp_rd != exp_n) begin
			errors++;
			$display("%s: %0d predicted stores never happened", name, exp_n - exp_rd);
		end
		stores += exp_rd;
	endtask

	task automatic load_alu();
		wp = RESET_PC;
		emit_long(OP_LDI, 0, 0, 8'hA5);
		emit_long(OP_LDI, 1, 0, 8'h5B);
		emit_long(OP_LDI, 2, 0, 8'h3C);
		emit_long(OP_LDI, 3, 0, 8'h81);
		emit_short(OP_ADD, 0, 1);
		emit_long(OP_ST, 0, 0, 8'hC0);
		emit_short(OP_SUB, 2, 3);
		emit_long(OP_ST, 2, 0, 8'hC1);
		emit_short(OP_AND, 3, 1);
		emit_long(OP_ST, 3, 0, 8'hC2);
		emit_short(OP_OR, 1, 2);
		emit_long(OP_ST, 1, 0, 8'hC3);
		emit_short(OP_XOR, 2, 0);
		emit_long(OP_ST, 2, 0, 8'hC4);
		emit_short(OP_SHL, 3, 0);
		emit_long(OP_ST, 3, 0, 8'hC5);
		emit_short(OP_SHR, 1, 0);
		emit_long(OP_ST, 1, 0, 8'hC6);
		emit_short(OP_HLT, 0, 0);
	endtask

	task automatic load_move();
		wp = RESET_PC;
		emit_long(OP_LDI, 1, 0, 8'h7E);
		emit_short(OP_NOP, 0, 0);
		emit_long(OP_ST, 1, 0, 8'hC8);
		emit_short(OP_MOV, 2, 1);
		emit_long(OP_LD, 3, 0, 8'hC8);
		emit_long(OP_ST, 2, 0, 8'hC9);
		emit_long(OP_ST, 3, 0, 8'hCA);
		emit_short(OP_OR, 1, 1);
		emit_long(OP_LDI, 0, 0, 8'h00);
		emit_long(OP_JZ, 0, 0, wp + 8'd4);
		emit_long(OP_ST, 0, 0, 8'hCB);  // Runs since LDI leaves zero clear
		emit_short(OP_SUB, 1, 2);
		emit_long(OP_LDI, 0, 0, 8'h55);
		emit_short(OP_MOV, 3, 0);
		emit_long(OP_LD, 2, 0, 8'hC9);
		emit_long(OP_JZ, 0, 0, wp + 8'd4);
		emit_long(OP_ST, 3, 0, 8'hCC);
		emit_long(OP_JC, 0, 0, wp + 8'd4);
		emit_long(OP_ST, 2, 0, 8'hCD);
		emit_long(OP_ST, 3, 0, 8'hCE);
		emit_short(OP_HLT, 0, 0);
	endtask

	task automatic load_branch();
		wp = RESET_PC;
		emit_long(OP_LDI, 0, 0, 8'h01);
		emit_long(OP_LDI, 1, 0, 8'hFF);
		emit_long(OP_JMP, 0, 0, wp + 8'd4);
		emit_long(OP_ST, 0, 0, 8'hD0);
		emit_short(OP_ADD, 1, 0);  // Wraps to zero with carry
		emit_long(OP_JZ, 0, 0, wp + 8'd4);
		emit_long(OP_ST, 0, 0, 8'hD1);
		emit_long(OP_JC, 0, 0, wp + 8'd4);
		emit_long(OP_ST, 0, 0, 8'hD2);
		emit_long(OP_ST, 1, 0, 8'hD3);
		emit_short(OP_ADD, 0, 0);
		emit_long(OP_JZ, 0, 0, wp + 8'd4);
		emit_long(OP_ST, 0, 0, 8'hD4);
		emit_long(OP_JC, 0, 0, wp + 8'd4);
		emit_long(OP_ST, 0, 0, 8'hD5);
		emit_short(OP_HLT, 0, 0);
	endtask

	task automatic load_random();
		int      count;
		int      i;
		opcode_e op;
		wp    = RESET_PC;
		count = 8 + int'($urandom % 16);
		for (i = 0; i < 4; i++)
			emit_long(OP_LDI, i, 0, 8'($urandom));
		for (i = 0; i < count; i++) begin
			op = opcode_e'(4'($urandom % 12));  // NOP through MOV
			if (op == OP_ST)
				emit_long(op, int'($urandom % 4), 0, 8'hC0 | 8'($urandom % 64));
			else if (op == OP_LDI || op == OP_LD)
				emit_long(op, int'($urandom % 4), 0, 8'($urandom));
			else
				emit_short(op, int'($urandom % 4), int'($urandom % 4));
		end
		for (i = 0; i < 4; i++)
			emit_long(OP_ST, i, 0, 8'hE0 + 8'(i));
		emit_short(OP_HLT, 0, 0);
	endtask

	initial begin
		int i;
		rst_n    = 1'b0;
		exp_halt = 1'b0;
		errors   = 0;
		stores   = 0;
		wp       = RESET_PC;
		void'($urandom(47));
		for (i = 0; i < 256; i++)
			mem[i] = 8'(i * 7) ^ 8'h3C;
		load_alu();
		run_program("ALU instructions");
		load_move();
		run_program("data movement");
		load_branch();
		run_program("branches");
		for (i = 0; i < 20; i++) begin
			load_random();
			run_program("random program");
		end
		load_alu();
		restart();
		repeat (30) @(posedge clk);  // Stop the core part way through
		run_program("reset mid-run");
		$display("Stores checked: %0d, errors: %0d", stores, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* design/cpu_top.sv */
// Top level of the microprogrammed CPU
// Control unit, datapath and ALU on one byte-wide memory bus

`timescale 1ns/1ps

module cpu_top #(
	parameter logic [7:0] RESET_PC = 8'h00
) (
	input  logic       clk,
	input  logic       rst_n,
	output logic [7:0] mem_addr,
	output logic       mem_rd,
	output logic       mem_wr,
	output logic [7:0] mem_wdata,
	input  logic [7:0] mem_rdata,
	output logic       halted
);
	import cu_pkg::*;

	logic [UADDR_W-1:0] upc;
	micro_word_t        uword;
	opcode_e            opcode;
	logic               zero;
	logic               carry;
	alu_op_e            alu_op;
	logic [7:0]         alu_a;
	logic [7:0]         alu_b;
	logic [7:0]         alu_result;
	logic               alu_carry;
	logic               alu_zero;

	microsequencer u_seq (
		.clk    (clk),
		.rst_n  (rst_n),
		.uword  (uword),
		.opcode (opcode),
		.zero   (zero),
		.carry  (carry),
		.upc    (upc),
		.halted (halted)
	);

	microstore_rom u_rom (
		.index (upc),
		.out   (uword)
	);

	datapath #(
		.RESET_PC (RESET_PC)
	) u_dp (
		.clk        (clk),
		.rst_n      (rst_n),
		.uword      (uword),
		.halted     (halted),
		.mem_rdata  (mem_rdata),
		.alu_result (alu_result),
		.alu_carry  (alu_carry),
		.alu_zero   (alu_zero),
		.opcode     (opcode),
		.zero       (zero),
		.carry      (carry),
		.mem_addr   (mem_addr),
		.mem_rd     (mem_rd),
		.mem_wr     (mem_wr),
		.mem_wdata  (mem_wdata),
		.alu_op     (alu_op),
		.alu_a      (alu_a),
		.alu_b      (alu_b)
	);

	alu u_alu (
		.op       (alu_op),
		.a        (alu_a),
		.b        (alu_b),
		.carry_in (carry),
		.result   (alu_result),
		.carry    (alu_carry),
		.zero     (alu_zero)
	);

endmodule

/* datapath/datapath.sv */
// CPU datapath steered by the microword
// PC, IR, MAR, four general registers, flags, internal bus and memory strobes

`timescale 1ns/1ps

module datapath #(
	parameter logic [7:0] RESET_PC = 8'h00
) (
	input  logic                clk,
	input  logic                rst_n,
	input  cu_pkg::micro_word_t uword,
	input  logic                halted,
	input  logic [7:0]          mem_rdata,
	input  logic [7:0]          alu_result,
	input  logic                alu_carry,
	input  logic                alu_zero,
	output cu_pkg::opcode_e     opcode,
	output logic                zero,
	output logic                carry,
	output logic [7:0]          mem_addr,
	output logic                mem_rd,
	output logic                mem_wr,
	output logic [7:0]          mem_wdata,
	output cu_pkg::alu_op_e     alu_op,
	output logic [7:0]          alu_a,
	output logic [7:0]          alu_b
);
	import cu_pkg::*;

	logic [7:0] pc;
	logic [7:0] ir;
	logic [7:0] mar;
	logic [7:0] rf [4];
	logic [1:0] rd;
	logic [1:0] rs;
	logic [7:0] pre_bus;
	logic [7:0] bus;

	assign opcode = opcode_e'(ir[7:4]);
	assign rd     = ir[3:2];
	assign rs     = ir[1:0];

	// The ALU sees the bus value the mux would carry without the ALU tap
	always_comb begin
		case (uword.bus_src)
			SRC_MEM:    pre_bus = mem_rdata;
			SRC_REG_RD: pre_bus = rf[rd];
			default:    pre_bus = rf[rs];
		endcase
	end

	assign bus = (uword.bus_src == SRC_ALU) ? alu_result : pre_bus;

	assign alu_op = uword.alu_op;
	assign alu_a  = rf[rd];
	assign alu_b  = pre_bus;

	assign mem_addr  = uword.addr_from_mar ? mar : pc;
	assign mem_wdata = bus;
	assign mem_rd    = uword.mem_rd & ~halted;
	assign mem_wr    = uword.mem_wr & ~halted;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc    <= RESET_PC;
			ir    <= 8'h00;
			mar   <= 8'h00;
			zero  <= 1'b0;
			carry <= 1'b0;
		end else begin
			if (uword.pc_ld)
				pc <= bus;
			else if (uword.pc_inc)
				pc <= pc + 8'd1;
			if (uword.ir_ld)
				ir <= bus;
			if (uword.mar_ld)
				mar <= bus;
			if (uword.flags_ld) begin
				zero  <= alu_zero;
				carry <= alu_carry;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (uword.rf_we)
			rf[rd] <= bus;  // Destination is always the rd field
	end

	// Stores only go to the operand address, never to the instruction stream
	wr_from_mar: assert property (@(posedge clk) disable iff (!rst_n)
			mem_wr |-> uword.addr_from_mar)
		else $error("mem_wr with address from PC 0x%0h", pc);

endmodule

/* control_unit/microsequencer.sv */
// Micro-program counter and next-address selection
// Opcode dispatch, flag branches and the sticky halt register

`timescale 1ns/1ps

module microsequencer (
	input  logic                       clk,
	input  logic                       rst_n,
	input  cu_pkg::micro_word_t        uword,
	input  cu_pkg::opcode_e            opcode,
	input  logic                       zero,
	input  logic                       carry,
	output logic [cu_pkg::UADDR_W-1:0] upc,
	output logic                       halted
);
	import cu_pkg::*;

	localparam int LAST_UADDR = DISPATCH_BASE + ROUTINE_STRIDE * 15;

	logic [UADDR_W-1:0] upc_next;
	logic [UADDR_W-1:0] dispatch_addr;

	assign dispatch_addr = UADDR_W'(DISPATCH_BASE + ROUTINE_STRIDE * int'(opcode));

	always_comb begin
		case (uword.seq_op)
			SEQ_NEXT:     upc_next = upc + 1'b1;
			SEQ_JUMP:     upc_next = uword.next_addr;
			SEQ_DISPATCH: upc_next = dispatch_addr;
			SEQ_BR_ZERO:  upc_next = zero ? uword.next_addr : upc + 1'b1;
			SEQ_BR_CARRY: upc_next = carry ? uword.next_addr : upc + 1'b1;
			default:      upc_next = upc;  // HALT holds the current word
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			upc    <= UADDR_W'(FETCH_UADDR);
			halted <= 1'b0;
		end else begin
			upc <= upc_next;
			if (uword.seq_op == SEQ_HALT)
				halted <= 1'b1;
		end
	end

	halted_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
		else $error("halted fell without a reset");

	upc_in_range: assert property (@(posedge clk) disable iff (!rst_n) upc <= LAST_UADDR)
		else $error("upc 0x%0h beyond the last routine", upc);

endmodule

/* control_unit/microstore_rom.sv */
// Combinational microcode ROM
// Fetch, dispatch and one routine per opcode at its dispatch slot

`timescale 1ns/1ps

module microstore_rom (
	input  logic [cu_pkg::UADDR_W-1:0] index,
	output cu_pkg::micro_word_t        out
);
	import cu_pkg::*;

	// ctl order: addr_from_mar mem_rd mem_wr pc_inc pc_ld ir_ld mar_ld rf_we flags_ld
	function automatic micro_word_t uw(seq_op_e seq, logic [UADDR_W-1:0] nxt, alu_op_e alu,
			bus_src_e src, logic [8:0] ctl);
		micro_word_t w;
		w               = '0;
		w.next_addr     = nxt;
		w.seq_op        = seq;
		w.alu_op        = alu;
		w.bus_src       = src;
		w.addr_from_mar = ctl[8];
		w.mem_rd        = ctl[7];
		w.mem_wr        = ctl[6];
		w.pc_inc        = ctl[5];
		w.pc_ld         = ctl[4];
		w.ir_ld         = ctl[3];
		w.mar_ld        = ctl[2];
		w.rf_we         = ctl[1];
		w.flags_ld      = ctl[0];
		return w;
	endfunction

	always_comb begin
		case (index)
			// Fetch reads the opcode byte at the PC, then dispatch
			7'd0:  out = uw(SEQ_NEXT,     7'd0,  ALU_PASS_B, SRC_MEM,    9'b010101000);
			7'd1:  out = uw(SEQ_DISPATCH, 7'd0,  ALU_PASS_B, SRC_MEM,    9'b000000000);
			7'd8:  out = uw(SEQ_JUMP,     7'd0,  ALU_PASS_B, SRC_MEM,    9'b000000000);
			7'd12: out = uw(SEQ_JUMP,     7'd0,  ALU_PASS_B, SRC_MEM,    9'b010100010);
			7'd16: out = uw(SEQ_NEXT,     7'd0,  ALU_PASS_B, SRC_MEM,    9'b010100100);
			7'd17: out = uw(SEQ_JUMP,     7'd0,  ALU_PASS_B, SRC_MEM,    9'b110000010);
			7'd20: out = uw(SEQ_NEXT,     7'd0,  ALU_PASS_B, SRC_MEM,    9'b010100100);
			7'd21: out = uw(SEQ_JUMP,     7'd0,  ALU_PASS_B, SRC_REG_RD, 9'b101000000);
			7'd24: out = uw(SEQ_JUMP,     7'd0,  ALU_ADD,    SRC_ALU,    9'b000000011);
			7'd28: out = uw(SEQ_JUMP,     7'd0,  ALU_SUB,    SRC_ALU,    9'b000000011);
			7'd32: out = uw(SEQ_JUMP,     7'd0,  ALU_AND,    SRC_ALU,    9'b000000011);
			7'd36: out = uw(SEQ_JUMP,     7'd0,  ALU_OR,     SRC_ALU,    9'b000000011);
			7'd40: out = uw(SEQ_JUMP,     7'd0,  ALU_XOR,    SRC_ALU,    9'b000000011);
			7'd44: out = uw(SEQ_JUMP,     7'd0,  ALU_SHL,    SRC_ALU,    9'b000000011);
			7'd48: out = uw(SEQ_JUMP,     7'd0,  ALU_SHR,    SRC_ALU,    9'b000000011);
			7'd52: out = uw(SEQ_JUMP,     7'd0,  ALU_PASS_B, SRC_REG_RS, 9'b000000010);
			7'd56: out = uw(SEQ_JUMP,     7'd0,  ALU_PASS_B, SRC_MEM,    9'b010010000);
			// Conditional jumps skip the address byte when not taken
			7'd60: out = uw(SEQ_BR_ZERO,  7'd62, ALU_PASS_B, SRC_MEM,    9'b000000000);
			7'd61: out = uw(SEQ_JUMP,     7'd0,  ALU_PASS_B, SRC_MEM,    9'b000100000);
			7'd62: out = uw(SEQ_JUMP,     7'd0,  ALU_PASS_B, SRC_MEM,    9'b010010000);
			7'd64: out = uw(SEQ_BR_CARRY, 7'd66, ALU_PASS_B, SRC_MEM,    9'b000000000);
			7'd65: out = uw(SEQ_JUMP,     7'd0,  ALU_PASS_B, SRC_MEM,    9'b000100000);
			7'd66: out = uw(SEQ_JUMP,     7'd0,  ALU_PASS_B, SRC_MEM,    9'b010010000);
			7'd68: out = uw(SEQ_HALT,     7'd0,  ALU_PASS_B, SRC_MEM,    9'b000000000);
			default: out = uw(SEQ_HALT,   7'd0,  ALU_PASS_B, SRC_MEM,    9'b000000000);
		endcase
	end

	// A read and a write in one word would put two bus cycles in one clock
	always_comb begin
		assert (!(out.mem_rd && out.mem_wr))
			else $error("microword at %0d sets mem_rd and mem_wr", index);
	end

endmodule

/* design/alu.sv */
// Eight-bit ALU with carry and zero outputs

`timescale 1ns/1ps

module alu (
	input  cu_pkg::alu_op_e op,
	input  logic [7:0]      a,
	input  logic [7:0]      b,
	input  logic            carry_in,
	output logic [7:0]      result,
	output logic            carry,
	output logic            zero
);
	import cu_pkg::*;

	logic [8:0] sum;

	assign sum = {1'b0, a} + {1'b0, b};

	always_comb begin
		carry = 1'b0;
		case (op)
			ALU_ADD: begin
				result = sum[7:0];
				carry  = sum[8];
			end
			ALU_SUB: begin
				result = a - b;
				carry  = (a >= b);  // Set when no borrow
			end
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SHL: begin
				result = {a[6:0], 1'b0};
				carry  = a[7];
			end
			ALU_SHR: begin
				result = {1'b0, a[7:1]};
				carry  = a[0];
			end
			default: begin
				result = b;
				carry  = carry_in;
			end
		endcase
	end

	assign zero = (result == 8'h00);

endmodule

/* common/cu_pkg.sv */
// Shared definitions for the microprogrammed CPU
// Opcodes, sequencer and ALU enums, bus sources, microword layout, dispatch constants

package cu_pkg;

	parameter int UADDR_W        = 7;
	parameter int UWORD_W        = 45;
	parameter int FETCH_UADDR    = 0;
	parameter int DISPATCH_BASE  = 8;
	parameter int ROUTINE_STRIDE = 4;

	// Byte one of an instruction is {opcode, rd, rs}
	typedef enum logic [3:0] {
		OP_NOP,
		OP_LDI,
		OP_LD,
		OP_ST,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SHL,
		OP_SHR,
		OP_MOV,
		OP_JMP,
		OP_JZ,
		OP_JC,
		OP_HLT
	} opcode_e;

	typedef enum logic [2:0] {
		SEQ_NEXT,
		SEQ_JUMP,
		SEQ_DISPATCH,
		SEQ_BR_ZERO,
		SEQ_BR_CARRY,
		SEQ_HALT
	} seq_op_e;

	typedef enum logic [2:0] {
		ALU_PASS_B,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SHL,
		ALU_SHR
	} alu_op_e;

	typedef enum logic [1:0] {
		SRC_MEM,
		SRC_REG_RS,
		SRC_ALU,
		SRC_REG_RD
	} bus_src_e;

	typedef struct packed {
		logic [UADDR_W-1:0] next_addr;  // Target for JUMP and the flag branches
		seq_op_e            seq_op;
		alu_op_e            alu_op;
		bus_src_e           bus_src;
		logic               addr_from_mar;
		logic               mem_rd;
		logic               mem_wr;
		logic               pc_inc;
		logic               pc_ld;
		logic               ir_ld;
		logic               mar_ld;
		logic               rf_we;
		logic               flags_ld;
		logic [20:0]        reserved;  // Always zero
	} micro_word_t;

endpackage
